// ==== hdl/chipset_pkg.sv ====
package chipset_pkg;

    // Bus word for addresses and data
    typedef logic [31:0] word_t;

    // Byte write mask, bit n enables byte n
    localparam int BYTES_PER_WORD = 4;
    typedef logic [BYTES_PER_WORD-1:0] mask_t;

    // Peripheral bank count, any value from 1 to 16 fits the map
    localparam int NUM_BANKS = 4;

    // Registers per bank, picked by address bits 3:2
    localparam int REGS_PER_BANK = 4;
    localparam int REG_IDX_W     = $clog2(REGS_PER_BANK);
    localparam int REG_IDX_LSB   = 2;

    // Upper 20 address bits of the MMIO window
    localparam logic [19:0] MMIO_BASE = 20'hFFFF0;

    // Bank index lives in address bits 11:8
    localparam int BANK_STRIDE_BITS = 8;
    localparam int BANK_IDX_W       = 4;

    // Request payload
    typedef struct packed {
        logic  write;
        word_t addr;
        word_t wdata;
        mask_t mask;
    } bus_req_t;

    // Response payload
    typedef struct packed {
        word_t rdata;
        logic  err;
    } bus_rsp_t;

endpackage

// ==== hdl/bus_reg_slice.sv ====
module bus_reg_slice
    #(
        parameter type payload_t = logic
    )
    (
        // Clock and reset
        input  wire logic clk_i,
        input  wire logic reset_i,

        // Upstream side
        input  wire logic in_valid_i,
        output      logic in_ready_o,
        input  payload_t  in_data_i,

        // Downstream side
        output      logic out_valid_o,
        input  wire logic out_ready_i,
        output payload_t  out_data_o
    );

// Output entry
logic     out_valid_q;
payload_t out_data_q;

// Skid entry, only filled while the output stalls
logic     skid_valid_q;
payload_t skid_data_q;

// Output entry empty or leaving this cycle
logic out_free;
logic in_fire;

// Ready comes straight from a flop, no path from out_ready_i
assign in_ready_o = !skid_valid_q;
assign in_fire    = in_valid_i && in_ready_o;
assign out_free   = !out_valid_q || out_ready_i;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        out_valid_q  <= 1'b0;
        skid_valid_q <= 1'b0;
    end else if (out_free) begin
        // Skid entry is older, it goes out first
        if (skid_valid_q) begin
            out_valid_q  <= 1'b1;
            skid_valid_q <= 1'b0;
        end else begin
            out_valid_q <= in_valid_i;
        end
    end else if (in_fire) begin
        // Output stalled, park the new entry
        skid_valid_q <= 1'b1;
    end
end

// Payload storage
always_ff @(posedge clk_i) begin
    if (out_free) begin
        if (skid_valid_q) begin
            out_data_q <= skid_data_q;
        end else if (in_valid_i) begin
            out_data_q <= in_data_i;
        end
    end else if (in_fire) begin
        skid_data_q <= in_data_i;
    end
end

assign out_valid_o = out_valid_q;
assign out_data_o  = out_data_q;

endmodule

// ==== hdl/chip_select_decode.sv ====
module chip_select_decode
    import chipset_pkg::*;
    (
        // Request from the request slice
        input  wire logic                 req_valid_i,
        output      logic                 req_ready_o,
        input  wire word_t                req_addr_i,

        // Response slice input ready
        input  wire logic                 rsp_ready_i,

        // Bank side
        output      logic                 access_o,
        output      logic [NUM_BANKS-1:0] bank_sel_o,
        output      logic [REG_IDX_W-1:0] reg_idx_o,

        // Unmapped access
        output      logic                 miss_o
    );

// Address fields
logic [BANK_IDX_W-1:0] bank_idx;
logic                  prefix_hit;
logic                  bank_in_range;
logic                  pad_zero;
logic                  hit;

assign bank_idx = req_addr_i[BANK_STRIDE_BITS +: BANK_IDX_W];

// FFFF0xxx window
assign prefix_hit = (req_addr_i[31:BANK_STRIDE_BITS+BANK_IDX_W] == MMIO_BASE);

// Bank must exist, extra bit keeps a count of 16 comparable
assign bank_in_range = ({1'b0, bank_idx} < (BANK_IDX_W+1)'(NUM_BANKS));

// Bits 7:4 above the register offset must be clear
assign pad_zero = (req_addr_i[BANK_STRIDE_BITS-1:REG_IDX_LSB+REG_IDX_W] == '0);

assign hit    = prefix_hit && bank_in_range && pad_zero;
assign miss_o = !hit;

// Register offset, byte lane bits ignored
assign reg_idx_o = req_addr_i[REG_IDX_LSB +: REG_IDX_W];

// One-hot select, all zero on a miss
always_comb begin
    bank_sel_o = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
        if (hit && (bank_idx == BANK_IDX_W'(i))) begin
            bank_sel_o[i] = 1'b1;
        end
    end
end

// Commit point, request leaves exactly when the response is taken
assign req_ready_o = rsp_ready_i;
assign access_o    = req_valid_i && rsp_ready_i;

endmodule

// ==== hdl/mmio_reg_bank.sv ====
module mmio_reg_bank
    import chipset_pkg::*;
    (
        // Clock and reset
        input  wire logic                 clk_i,
        input  wire logic                 reset_i,

        // Access from the decoder
        input  wire logic                 sel_i,
        input  wire logic                 access_i,
        input  wire logic                 write_i,
        input  wire logic [REG_IDX_W-1:0] reg_idx_i,
        input  wire word_t                wdata_i,
        input  wire mask_t                mask_i,

        // Read port, zero when not selected
        output      word_t                rdata_o
    );

// Register file
word_t regs_q [REGS_PER_BANK];

// Current value of the addressed register
word_t cur_word;

// Addressed register with enabled bytes replaced
word_t merged_word;

logic wr_en;

assign cur_word = regs_q[reg_idx_i];

// Byte lane merge
always_comb begin
    merged_word = cur_word;
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (mask_i[b]) begin
            merged_word[b*8 +: 8] = wdata_i[b*8 +: 8];
        end
    end
end

// Write only on the committing cycle
assign wr_en = access_i && sel_i && write_i;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int r = 0; r < REGS_PER_BANK; r++) begin
            regs_q[r] <= '0;
        end
    end else if (wr_en) begin
        regs_q[reg_idx_i] <= merged_word;
    end
end

// Reads see the old value, writes echo the merged value
assign rdata_o = !sel_i  ? '0          :
                 write_i ? merged_word : cur_word;

endmodule

// ==== hdl/read_return_mux.sv ====
module read_return_mux
    import chipset_pkg::*;
    (
        // Per-bank read data
        input  wire word_t    bank_rdata_i [NUM_BANKS],

        // Unmapped address flag
        input  wire logic     miss_i,

        // Response payload
        output      bus_rsp_t rsp_o
    );

// OR of all banks
word_t merged_rdata;

// Unselected banks drive zero, so a plain OR picks the hit
always_comb begin
    merged_rdata = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
        merged_rdata = merged_rdata | bank_rdata_i[i];
    end
end

// Miss forces zero data and flags an error
always_comb begin
    if (miss_i) begin
        rsp_o.rdata = '0;
        rsp_o.err   = 1'b1;
    end else begin
        rsp_o.rdata = merged_rdata;
        rsp_o.err   = 1'b0;
    end
end

endmodule

// ==== hdl/chipset_bus.sv ====
module chipset_bus
    import chipset_pkg::*;
    (
        // Clock and reset
        input  wire logic  clk_i,
        input  wire logic  reset_i,

        // Request port
        input  wire logic  req_valid_i,
        output      logic  req_ready_o,
        input  wire logic  req_write_i,
        input  wire word_t req_addr_i,
        input  wire word_t req_wdata_i,
        input  wire mask_t req_mask_i,

        // Response port
        output      logic  rsp_valid_o,
        input  wire logic  rsp_ready_i,
        output      word_t rsp_rdata_o,
        output      logic  rsp_err_o
    );

// Request into and out of the request slice
bus_req_t req_in;
bus_req_t req_q;
logic     req_q_valid;
logic     req_q_ready;

// Response into and out of the response slice
bus_rsp_t rsp_in;
bus_rsp_t rsp_q;
logic     rsp_in_ready;

// Decoder outputs
logic                 access;
logic [NUM_BANKS-1:0] bank_sel;
logic [REG_IDX_W-1:0] reg_idx;
logic                 miss;

// Per-bank read data
word_t bank_rdata [NUM_BANKS];

// Pack loose request fields
assign req_in.write = req_write_i;
assign req_in.addr  = req_addr_i;
assign req_in.wdata = req_wdata_i;
assign req_in.mask  = req_mask_i;

bus_reg_slice #(
    .payload_t   (bus_req_t)
) i_req_slice (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (req_in),
    .out_valid_o (req_q_valid),
    .out_ready_i (req_q_ready),
    .out_data_o  (req_q)
);

chip_select_decode i_chip_select_decode (
    .req_valid_i (req_q_valid),
    .req_ready_o (req_q_ready),
    .req_addr_i  (req_q.addr),
    .rsp_ready_i (rsp_in_ready),
    .access_o    (access),
    .bank_sel_o  (bank_sel),
    .reg_idx_o   (reg_idx),
    .miss_o      (miss)
);

// Identical banks, one per 256-byte window
for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    mmio_reg_bank i_mmio_reg_bank (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .sel_i     (bank_sel[i]),
        .access_i  (access),
        .write_i   (req_q.write),
        .reg_idx_i (reg_idx),
        .wdata_i   (req_q.wdata),
        .mask_i    (req_q.mask),
        .rdata_o   (bank_rdata[i])
    );
end

read_return_mux i_read_return_mux (
    .bank_rdata_i (bank_rdata),
    .miss_i       (miss),
    .rsp_o        (rsp_in)
);

// Capture happens on the same cycle as the bank write
bus_reg_slice #(
    .payload_t   (bus_rsp_t)
) i_rsp_slice (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (req_q_valid),
    .in_ready_o  (rsp_in_ready),
    .in_data_i   (rsp_in),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i),
    .out_data_o  (rsp_q)
);

// Unpack response fields
assign rsp_rdata_o = rsp_q.rdata;
assign rsp_err_o   = rsp_q.err;

endmodule

// ==== verification/chipset_bus_asserts.sv ====
module chipset_bus_asserts
    import chipset_pkg::*;
    (
        // Taps on the DUT ports
        input wire logic  clk_i,
        input wire logic  reset_i,
        input wire logic  req_ready_o,
        input wire logic  rsp_valid_o,
        input wire logic  rsp_ready_i,
        input wire word_t rsp_rdata_o,
        input wire logic  rsp_err_o
    );

timeunit 1ns;
timeprecision 1ps;

// Stalled response keeps valid and payload
property p_rsp_stable;
    @(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o);
endproperty

a_rsp_stable: assert property (p_rsp_stable)
    else $error("Response valid or payload changed while stalled");

// First cycle out of reset
a_ready_after_reset: assert property (
    @(posedge clk_i) $fell(reset_i) |-> req_ready_o && !rsp_valid_o)
    else $error("Request ready low or response valid high right after reset");

// Error responses never carry data
a_err_zero_data: assert property (
    @(posedge clk_i) disable iff (reset_i) rsp_valid_o && rsp_err_o |-> rsp_rdata_o == '0)
    else $error("Error response with nonzero read data");

endmodule

bind chipset_bus chipset_bus_asserts i_chipset_bus_asserts (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
);

// ==== verification/chipset_bus_tb.sv ====
module chipset_bus_tb
    import chipset_pkg::*;
    ();

timeunit 1ns;
timeprecision 1ps;

localparam logic [31:0] SEED       = 32'hbc5f1f20;
localparam int          SEND_LIMIT = 200;
localparam int          DRAIN_LIMIT = 500;

// DUT ports
logic  clk_i;
logic  reset_i;
logic  req_valid_i;
logic  req_ready_o;
logic  req_write_i;
word_t req_addr_i;
word_t req_wdata_i;
mask_t req_mask_i;
logic  rsp_valid_o;
logic  rsp_ready_i;
word_t rsp_rdata_o;
logic  rsp_err_o;

// Separate streams for stimulus and back-pressure
logic [31:0] stim_state;
logic [31:0] bp_state;

// 0 ready high, 1 random dropouts, 2 ready low
int   bp_mode;
logic latency_check;
int   cycle;

// Reference model and expected responses
word_t model_regs [NUM_BANKS][REGS_PER_BANK];
word_t exp_data_q [$];
logic  exp_err_q [$];
int    exp_cycle_q [$];

// Most recent accepted response
word_t last_rdata;
logic  last_err;

int data_errors;
int latency_errors;
int state_errors;
int timeouts;

chipset_bus i_chipset_bus (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_mask_i  (req_mask_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
);

always #2 clk_i = ~clk_i;

// Edge count for latency
always @(posedge clk_i) begin
    cycle <= cycle + 1;
end

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] rand_word();
    stim_state = xorshift32(stim_state);
    return stim_state;
endfunction

// Register address from bank and index
function automatic word_t reg_addr(input int bank, input int idx);
    return {MMIO_BASE, 4'(bank), 4'h0, 2'(idx), 2'b00};
endfunction

// Hit needs the prefix, an existing bank and bits 7:4 clear
function automatic logic model_hit(input word_t a);
    return (a[31:12] == MMIO_BASE) && (int'(a[BANK_STRIDE_BITS +: 4]) < NUM_BANKS) &&
           (a[7:4] == 4'h0);
endfunction

function automatic word_t apply_mask(input word_t old_w, input word_t new_w, input mask_t m);
    word_t w;
    w = old_w;
    for (int i = 0; i < 4; i++) begin
        if (m[i]) begin
            w[i*8 +: 8] = new_w[i*8 +: 8];
        end
    end
    return w;
endfunction

// Response back-pressure
always @(posedge clk_i) begin
    if (bp_mode == 1) begin
        bp_state = xorshift32(bp_state);
        rsp_ready_i <= (bp_state[1:0] != 2'b00);
    end else begin
        rsp_ready_i <= (bp_mode == 0);
    end
end

// Monitor samples mid-cycle where everything is settled
always @(negedge clk_i) begin : monitor
    word_t cur;
    word_t e_data;
    logic  e_err;
    int    acc;
    int    b;
    int    r;
    if (!reset_i) begin
        // Handshake completes on the coming edge
        if (rsp_valid_o && rsp_ready_i) begin
            if (exp_data_q.size() == 0) begin
                $display("Response at %0t arrived with no request outstanding", $time);
                state_errors++;
            end else begin
                e_data = exp_data_q.pop_front();
                e_err  = exp_err_q.pop_front();
                acc    = exp_cycle_q.pop_front();
                if (rsp_rdata_o !== e_data || rsp_err_o !== e_err) begin
                    $display("FAILED t=%0t: rdata %h err %b, expected rdata %h err %b",
                             $time, rsp_rdata_o, rsp_err_o, e_data, e_err);
                    data_errors++;
                end
                if (latency_check && (cycle - acc != 2)) begin
                    $display("FAILED t=%0t: response %0d cycles after acceptance, expected 2",
                             $time, cycle - acc);
                    latency_errors++;
                end
            end
            last_rdata = rsp_rdata_o;
            last_err   = rsp_err_o;
        end
        // Model state moves in request order
        if (req_valid_i && req_ready_o) begin
            if (model_hit(req_addr_i)) begin
                b   = int'(req_addr_i[BANK_STRIDE_BITS +: 4]);
                r   = int'(req_addr_i[3:2]);
                cur = model_regs[b][r];
                if (req_write_i) begin
                    cur = apply_mask(cur, req_wdata_i, req_mask_i);
                    model_regs[b][r] = cur;
                end
                exp_data_q.push_back(cur);
                exp_err_q.push_back(1'b0);
            end else begin
                exp_data_q.push_back('0);
                exp_err_q.push_back(1'b1);
            end
            exp_cycle_q.push_back(cycle);
        end
    end
end

task automatic finish_run();
    int total;
    total = data_errors + latency_errors + state_errors + timeouts;
    $display("Errors: data %0d, latency %0d, state %0d, timeout %0d",
             data_errors, latency_errors, state_errors, timeouts);
    if (total == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
endtask

task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s did not happen within the cycle limit", $time, what);
    timeouts++;
    finish_run();
endtask

// Called on a rising edge and returns on the accepting edge
task automatic send(input logic wr, input word_t addr, input word_t data, input mask_t mask);
    int waited;
    req_valid_i <= 1'b1;
    req_write_i <= wr;
    req_addr_i  <= addr;
    req_wdata_i <= data;
    req_mask_i  <= mask;
    waited = 0;
    @(negedge clk_i);
    while (!req_ready_o && waited < SEND_LIMIT) begin
        @(negedge clk_i);
        waited++;
    end
    if (!req_ready_o) begin
        report_timeout("request acceptance");
    end
    @(posedge clk_i);
endtask

task automatic idle(input int n);
    req_valid_i <= 1'b0;
    repeat (n) @(posedge clk_i);
endtask

// Queue only changes on falling edges so it is polled on rising ones
task automatic wait_drain();
    int waited;
    req_valid_i <= 1'b0;
    waited = 0;
    @(posedge clk_i);
    while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT) begin
        @(posedge clk_i);
        waited++;
    end
    if (exp_data_q.size() != 0) begin
        report_timeout("response drain");
    end
endtask

task automatic set_backpressure(input int mode);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    bp_mode = mode;
    repeat (2) @(posedge clk_i);
endtask

task automatic read_all();
    for (int b = 0; b < NUM_BANKS; b++) begin
        for (int r = 0; r < REGS_PER_BANK; r++) begin
            send(1'b0, reg_addr(b, r), 32'h0, 4'h0);
        end
    end
endtask

// Mostly mapped registers with some misses of each kind
task automatic send_random();
    logic [31:0] r;
    word_t       addr;
    int          sel;
    int          bank;
    r    = rand_word();
    sel  = int'(r[7:0]) % 10;
    bank = int'(r[15:8]) % NUM_BANKS;
    if (sel < 8) begin
        addr = reg_addr(bank, int'(r[17:16]));
    end else if (sel == 8 && NUM_BANKS < 16) begin
        addr = {MMIO_BASE, (r[22] ? 4'hF : 4'(NUM_BANKS)), 4'h0, r[17:16], 2'b00};
    end else if (r[22]) begin
        addr = {MMIO_BASE, 4'(bank), r[26:23] | 4'h1, r[17:16], 2'b00};
    end else begin
        // Bit 16 clear breaks the FFFF0 prefix
        addr = rand_word() & 32'hFFFE_FFFF;
    end
    send(r[31], addr, rand_word(), r[30:27]);
endtask

initial begin
    logic [31:0] g;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_mask_i  = '0;
    rsp_ready_i = 1'b1;
    stim_state  = SEED;
    bp_state    = xorshift32(SEED);
    bp_mode     = 0;
    latency_check = 1'b0;
    cycle       = 0;
    last_rdata  = '0;
    last_err    = 1'b0;
    data_errors = 0;
    latency_errors = 0;
    state_errors = 0;
    timeouts    = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
        for (int r = 0; r < REGS_PER_BANK; r++) begin
            model_regs[b][r] = '0;
        end
    end

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
        $display("FAILED t=%0t: after reset req_ready %b rsp_valid %b",
                 $time, req_ready_o, rsp_valid_o);
        state_errors++;
    end
    @(posedge clk_i);

    // All registers zero out of reset
    read_all();
    wait_drain();

    // Byte-masked merge on the last bank
    send(1'b1, reg_addr(NUM_BANKS - 1, 2), 32'h1122_3344, 4'hF);
    send(1'b1, reg_addr(NUM_BANKS - 1, 2), 32'hAABB_CCDD, 4'b0101);
    send(1'b1, reg_addr(NUM_BANKS - 1, 2), 32'hFFFF_FFFF, 4'h0);
    send(1'b0, reg_addr(NUM_BANKS - 1, 2), 32'h0, 4'h0);
    wait_drain();
    if (last_rdata !== 32'h11BB_33DD || last_err !== 1'b0) begin
        $display("FAILED t=%0t: masked register reads %h, expected 11bb33dd", $time, last_rdata);
        data_errors++;
    end

    // Misses of every kind leave registers alone
    send(1'b1, 32'hFFFF_0010, 32'hFFFF_FFFF, 4'hF);
    send(1'b1, 32'h0000_1000, 32'hFFFF_FFFF, 4'hF);
    send(1'b1, 32'hFFFE_0104, 32'hFFFF_FFFF, 4'hF);
    if (NUM_BANKS < 16) begin
        send(1'b1, {MMIO_BASE, 4'(NUM_BANKS), 8'h04}, 32'hFFFF_FFFF, 4'hF);
    end
    wait_drain();
    if (last_rdata !== '0 || last_err !== 1'b1) begin
        $display("FAILED t=%0t: miss returned rdata %h err %b", $time, last_rdata, last_err);
        data_errors++;
    end
    read_all();
    wait_drain();

    // Bank 0 fully written while the others must hold
    for (int r = 0; r < REGS_PER_BANK; r++) begin
        send(1'b1, reg_addr(0, r), 32'hFFFF_FFFF, 4'hF);
    end
    read_all();
    wait_drain();

    // Back-to-back with ready high gives a fixed latency
    latency_check = 1'b1;
    repeat (32) send_random();
    wait_drain();
    latency_check = 1'b0;

    // With ready low both slices fill and request ready drops
    set_backpressure(2);
    repeat (4) send_random();
    idle(2);
    @(negedge clk_i);
    if (req_ready_o !== 1'b0 || rsp_valid_o !== 1'b1) begin
        $display("FAILED t=%0t: stalled bus shows req_ready %b rsp_valid %b",
                 $time, req_ready_o, rsp_valid_o);
        state_errors++;
    end
    @(posedge clk_i);
    set_backpressure(0);
    wait_drain();

    // Random traffic under random dropouts
    set_backpressure(1);
    repeat (300) begin
        g = rand_word();
        if (g[1:0] == 2'b00) begin
            idle(1 + int'(g[3:2]));
        end
        send_random();
    end
    wait_drain();
    set_backpressure(0);
    read_all();
    wait_drain();

    // Nothing may stay in flight once every expected response has arrived
    idle(4);
    @(negedge clk_i);
    if (exp_data_q.size() != 0 || rsp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
        $display("Bus not idle at the end: %0d responses expected, rsp_valid %b req_ready %b",
                 exp_data_q.size(), rsp_valid_o, req_ready_o);
        state_errors++;
    end
    finish_run();
end

endmodule

// ==== tb.f ====
hdl/chipset_pkg.sv
hdl/bus_reg_slice.sv
hdl/chip_select_decode.sv
hdl/mmio_reg_bank.sv
hdl/read_return_mux.sv
hdl/chipset_bus.sv
verification/chipset_bus_asserts.sv
verification/chipset_bus_tb.sv

// ==== Bender.yml ====
package:
  name: chipset_bus

sources:
  # RTL, package first
  - files:
      - hdl/chipset_pkg.sv
      - hdl/bus_reg_slice.sv
      - hdl/chip_select_decode.sv
      - hdl/mmio_reg_bank.sv
      - hdl/read_return_mux.sv
      - hdl/chipset_bus.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/chipset_bus_asserts.sv
      - verification/chipset_bus_tb.sv
